// File: verilog/rv_ctrl_params.svh
// Width and size macros for the pipeline control-flow block.
// Include this file wherever a width or a BTB size is needed. The package
// builds its typedefs on these values.

`ifndef RV_CTRL_PARAMS_SVH
`define RV_CTRL_PARAMS_SVH

// address and register widths.
`define RV_ADDR_W 32
`define RV_DATA_W 32

// direct-mapped BTB geometry.
`define BTB_ENTRIES 8
`define BTB_IDX_W 3

// tag covers address bits 31 down to 5.
`define BTB_TAG_W 27

// two-bit saturating counter per entry.
`define BTB_CNT_W 2

// a new entry starts weakly taken.
`define BTB_CNT_INIT 2

`endif

// File: verilog/rv_ctrl_pkg.sv
// Types shared by the control-flow block and its testbench.
// Refer to the members with rv_ctrl_pkg:: scoped names.

`include "rv_ctrl_params.svh"

package rv_ctrl_pkg;

	// fetch and jump addresses.
	typedef logic [`RV_ADDR_W-1:0] addr_t;

	// register operands compared by branches.
	typedef logic [`RV_DATA_W-1:0] data_t;

	// BTB index and tag, taken from the instruction address.
	typedef logic [`BTB_IDX_W-1:0] btb_idx_t;
	typedef logic [`BTB_TAG_W-1:0] btb_tag_t;

	// direction counter of a BTB entry.
	typedef logic [`BTB_CNT_W-1:0] btb_cnt_t;

	// jump class decoded for the instruction in execute.
	typedef enum logic [2:0] {
		JMP_NONE = 3'd0,
		JMP_BEQ  = 3'd1,
		JMP_BNE  = 3'd2,
		JMP_BLT  = 3'd3,
		JMP_BGE  = 3'd4,
		JMP_BLTU = 3'd5,
		JMP_BGEU = 3'd6,
		JMP_J    = 3'd7
	} jmp_flag_e;

	// hold request to the pipeline stages.
	typedef enum logic {
		HOLD_NONE = 1'b0,
		HOLD_EX   = 1'b1
	} hold_code_e;

endpackage

// File: verilog/branch_cmp.sv
// Branch resolution for the instruction in execute.
// Compares the register operands by the jump class and forms the target
// from the two operands supplied by decode.

`timescale 1ns/10ps

`include "rv_ctrl_params.svh"

module branch_cmp (
	input  rv_ctrl_pkg::jmp_flag_e jmp_flag_i,
	input  rv_ctrl_pkg::data_t     data_rs1_i,
	input  rv_ctrl_pkg::data_t     data_rs2_i,
	input  rv_ctrl_pkg::addr_t     jmp_num1_i,
	input  rv_ctrl_pkg::addr_t     jmp_num2_i,
	input  logic                   load_bypass_i,
	output logic                   res_taken_o,
	output rv_ctrl_pkg::addr_t     res_target_o
);

	logic rs1_eq_rs2;
	logic rs1_slt_rs2;
	logic rs1_sltu_rs2;
	logic cond_taken;

	assign rs1_eq_rs2   = (data_rs1_i == data_rs2_i);
	assign rs1_slt_rs2  = ($signed(data_rs1_i) < $signed(data_rs2_i));
	assign rs1_sltu_rs2 = (data_rs1_i < data_rs2_i);

	always_comb begin
		case (jmp_flag_i)
			rv_ctrl_pkg::JMP_BEQ: begin
				cond_taken = rs1_eq_rs2;
			end
			rv_ctrl_pkg::JMP_BNE: begin
				cond_taken = !rs1_eq_rs2;
			end
			rv_ctrl_pkg::JMP_BLT: begin
				cond_taken = rs1_slt_rs2;
			end
			rv_ctrl_pkg::JMP_BGE: begin
				cond_taken = !rs1_slt_rs2;
			end
			rv_ctrl_pkg::JMP_BLTU: begin
				cond_taken = rs1_sltu_rs2;
			end
			rv_ctrl_pkg::JMP_BGEU: begin
				cond_taken = !rs1_sltu_rs2;
			end
			rv_ctrl_pkg::JMP_J: begin
				cond_taken = 1'b1; // unconditional jumps ignore the operands.
			end
			default: begin
				cond_taken = 1'b0;
			end
		endcase
	end

	// operands are stale until the load result arrives.
	assign res_taken_o  = cond_taken && !load_bypass_i;
	assign res_target_o = res_taken_o ? (jmp_num1_i + jmp_num2_i) : '0;

endmodule

// File: verilog/btb_update.sv
// Write side of the BTB.
// Splits the resolving instruction address into index and tag and raises
// the write strobe of the selected entry. The resolved outcome is shared
// by all entries.

`timescale 1ns/10ps

`include "rv_ctrl_params.svh"

module btb_update (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     hold_n_i,
	input  rv_ctrl_pkg::addr_t       pc_instr_i,
	input  rv_ctrl_pkg::jmp_flag_e   jmp_flag_i,
	input  logic                     res_taken_i,
	input  rv_ctrl_pkg::addr_t       res_target_i,
	output logic [`BTB_ENTRIES-1:0]  wr_en_o,
	output rv_ctrl_pkg::btb_tag_t    wr_tag_o,
	output rv_ctrl_pkg::addr_t       wr_target_o,
	output logic                     wr_taken_o
);

	rv_ctrl_pkg::btb_idx_t wr_idx;
	logic                  is_jump;

	// word aligned, so bits 1:0 are skipped.
	assign wr_idx   = pc_instr_i[`BTB_IDX_W+1:2];
	assign wr_tag_o = pc_instr_i[`RV_ADDR_W-1:`BTB_IDX_W+2];

	assign is_jump = (jmp_flag_i != rv_ctrl_pkg::JMP_NONE);

	always_comb begin
		wr_en_o = '0;
		if (hold_n_i && is_jump) begin
			wr_en_o[wr_idx] = 1'b1;
		end
	end

	assign wr_target_o = res_target_i;
	assign wr_taken_o  = res_taken_i;

	// at most one entry is trained per resolved branch.
	a_wr_onehot: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		$onehot0(wr_en_o)
	);

endmodule

// File: verilog/btb_entry.sv
// One entry of the direct-mapped BTB.
// Holds valid, tag, target and a two-bit direction counter. Taken branches
// allocate on a miss; hits train the counter and refresh the target.

`timescale 1ns/10ps

`include "rv_ctrl_params.svh"

module btb_entry (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  wr_en_i,
	input  rv_ctrl_pkg::btb_tag_t wr_tag_i,
	input  rv_ctrl_pkg::addr_t    wr_target_i,
	input  logic                  wr_taken_i,
	output logic                  valid_o,
	output rv_ctrl_pkg::btb_tag_t tag_o,
	output rv_ctrl_pkg::addr_t    target_o,
	output rv_ctrl_pkg::btb_cnt_t cnt_o
);

	logic                  wr_hit;
	logic                  alloc;
	logic                  train;
	rv_ctrl_pkg::btb_cnt_t cnt_next;

	assign wr_hit = valid_o && (tag_o == wr_tag_i);
	assign alloc  = wr_en_i && !wr_hit && wr_taken_i; // not-taken misses leave the entry alone.
	assign train  = wr_en_i && wr_hit;

	always_comb begin
		cnt_next = cnt_o;
		if (alloc) begin
			cnt_next = rv_ctrl_pkg::btb_cnt_t'(`BTB_CNT_INIT);
		end else if (train) begin
			if (wr_taken_i && (cnt_o != '1)) begin
				cnt_next = cnt_o + 1'b1;
			end else if (!wr_taken_i && (cnt_o != '0)) begin
				cnt_next = cnt_o - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else if (alloc) begin
			valid_o <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			tag_o <= wr_tag_i;
		end
		if (alloc || (train && wr_taken_i)) begin
			target_o <= wr_target_i;
		end
		cnt_o <= cnt_next;
	end

	// an entry only becomes valid through a taken write.
	a_valid_rise: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		$rose(valid_o) |-> $past(wr_en_i && wr_taken_i)
	);

endmodule

// File: verilog/btb_lookup.sv
// Read side of the BTB.
// Picks the entry for the fetch address and gives the prediction in the
// same cycle. The prediction is kept for one cycle and checked against
// the outcome resolved in execute.

`timescale 1ns/10ps

`include "rv_ctrl_params.svh"

module btb_lookup (
	input  logic                                      clk,
	input  logic                                      rst_n_i,
	input  logic                                      hold_n_i,
	input  rv_ctrl_pkg::addr_t                        pc_pred_i,
	input  logic [`BTB_ENTRIES-1:0]                   valid_i,
	input  rv_ctrl_pkg::btb_tag_t [`BTB_ENTRIES-1:0]  tag_i,
	input  rv_ctrl_pkg::addr_t [`BTB_ENTRIES-1:0]     target_i,
	input  rv_ctrl_pkg::btb_cnt_t [`BTB_ENTRIES-1:0]  cnt_i,
	input  logic                                      res_taken_i,
	input  rv_ctrl_pkg::addr_t                        res_target_i,
	output logic                                      pred_taken_o,
	output rv_ctrl_pkg::addr_t                        pred_target_o,
	output logic                                      pred_error_o
);

	rv_ctrl_pkg::btb_idx_t rd_idx;
	rv_ctrl_pkg::btb_tag_t rd_tag;
	rv_ctrl_pkg::btb_cnt_t rd_cnt;
	logic                  rd_hit;
	logic                  pred_taken_q;
	rv_ctrl_pkg::addr_t    pred_target_q;
	logic                  target_diff;

	assign rd_idx = pc_pred_i[`BTB_IDX_W+1:2];
	assign rd_tag = pc_pred_i[`RV_ADDR_W-1:`BTB_IDX_W+2];
	assign rd_cnt = cnt_i[rd_idx];

	assign rd_hit = valid_i[rd_idx] && (tag_i[rd_idx] == rd_tag);

	// upper half of the counter range predicts taken.
	assign pred_taken_o  = rd_hit && rd_cnt[`BTB_CNT_W-1];
	assign pred_target_o = rd_hit ? target_i[rd_idx] : '0;

	// the instruction fetched now resolves in execute next cycle.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pred_taken_q  <= 1'b0;
			pred_target_q <= '0;
		end else if (hold_n_i) begin
			pred_taken_q  <= pred_taken_o;
			pred_target_q <= pred_target_o;
		end
	end

	assign target_diff = (pred_target_q != res_target_i);

	// wrong direction, or right direction to the wrong place.
	assign pred_error_o = (pred_taken_q != res_taken_i) ||
			(pred_taken_q && res_taken_i && target_diff);

endmodule

// File: verilog/ctrl.sv
// Control-flow block of the five-stage pipeline.
// Resolves branches in execute, predicts the next fetch address from the
// BTB and chooses the front-end redirect: interrupt, then misprediction
// fix, then predicted path. Also drives the hold code and squash mask.

`timescale 1ns/10ps

`include "rv_ctrl_params.svh"

module ctrl (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  rv_ctrl_pkg::addr_t      pc_pred_i,
	input  rv_ctrl_pkg::addr_t      pc_instr_i,
	input  rv_ctrl_pkg::addr_t      jmp_num1_i,
	input  rv_ctrl_pkg::addr_t      jmp_num2_i,
	input  rv_ctrl_pkg::data_t      data_rs1_i,
	input  rv_ctrl_pkg::data_t      data_rs2_i,
	input  rv_ctrl_pkg::jmp_flag_e  jmp_flag_i,
	input  logic                    load_bypass_i,
	input  logic                    stall_if_i,
	input  logic                    stall_mem_i,
	input  logic                    irq_jmp_i,
	input  rv_ctrl_pkg::addr_t      irq_jmp_to_i,
	output logic                    jmp_en_o,
	output rv_ctrl_pkg::addr_t      jmp_to_o,
	output logic                    instr_mask_o,
	output rv_ctrl_pkg::hold_code_e hold_code_o
);

	logic                                     res_taken;
	rv_ctrl_pkg::addr_t                       res_target;
	logic                                     hold_n;
	logic [`BTB_ENTRIES-1:0]                  wr_en;
	rv_ctrl_pkg::btb_tag_t                    wr_tag;
	rv_ctrl_pkg::addr_t                       wr_target;
	logic                                     wr_taken;
	logic [`BTB_ENTRIES-1:0]                  ent_valid;
	rv_ctrl_pkg::btb_tag_t [`BTB_ENTRIES-1:0] ent_tag;
	rv_ctrl_pkg::addr_t [`BTB_ENTRIES-1:0]    ent_target;
	rv_ctrl_pkg::btb_cnt_t [`BTB_ENTRIES-1:0] ent_cnt;
	logic                                     pred_taken;
	rv_ctrl_pkg::addr_t                       pred_target;
	logic                                     pred_error;
	logic                                     pred_error_q;
	logic                                     irq_jmp_q;

	assign hold_code_o = (stall_mem_i || stall_if_i) ? rv_ctrl_pkg::HOLD_EX :
			rv_ctrl_pkg::HOLD_NONE;
	assign hold_n = (hold_code_o == rv_ctrl_pkg::HOLD_NONE);

	branch_cmp u_branch_cmp (
		.jmp_flag_i    (jmp_flag_i),
		.data_rs1_i    (data_rs1_i),
		.data_rs2_i    (data_rs2_i),
		.jmp_num1_i    (jmp_num1_i),
		.jmp_num2_i    (jmp_num2_i),
		.load_bypass_i (load_bypass_i),
		.res_taken_o   (res_taken),
		.res_target_o  (res_target)
	);

	btb_update u_btb_update (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.hold_n_i     (hold_n),
		.pc_instr_i   (pc_instr_i),
		.jmp_flag_i   (jmp_flag_i),
		.res_taken_i  (res_taken),
		.res_target_i (res_target),
		.wr_en_o      (wr_en),
		.wr_tag_o     (wr_tag),
		.wr_target_o  (wr_target),
		.wr_taken_o   (wr_taken)
	);

	for (genvar i = 0; i < `BTB_ENTRIES; i++) begin : g_btb
		btb_entry u_btb_entry (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.wr_en_i     (wr_en[i]),
			.wr_tag_i    (wr_tag),
			.wr_target_i (wr_target),
			.wr_taken_i  (wr_taken),
			.valid_o     (ent_valid[i]),
			.tag_o       (ent_tag[i]),
			.target_o    (ent_target[i]),
			.cnt_o       (ent_cnt[i])
		);
	end

	btb_lookup u_btb_lookup (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.hold_n_i      (hold_n),
		.pc_pred_i     (pc_pred_i),
		.valid_i       (ent_valid),
		.tag_i         (ent_tag),
		.target_i      (ent_target),
		.cnt_i         (ent_cnt),
		.res_taken_i   (res_taken),
		.res_target_i  (res_target),
		.pred_taken_o  (pred_taken),
		.pred_target_o (pred_target),
		.pred_error_o  (pred_error)
	);

	always_comb begin
		if (irq_jmp_i) begin
			jmp_en_o = 1'b1;
			jmp_to_o = irq_jmp_to_i;
		end else if (pred_error) begin
			jmp_en_o = 1'b1; // fix the path taken by fetch.
			jmp_to_o = res_taken ? res_target : (pc_instr_i + rv_ctrl_pkg::addr_t'(4));
		end else begin
			jmp_en_o = pred_taken;
			jmp_to_o = pred_target;
		end
	end

	// wrong-path instructions get squashed one cycle after the redirect.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pred_error_q <= 1'b0;
			irq_jmp_q    <= 1'b0;
		end else if (hold_n) begin
			pred_error_q <= pred_error;
			irq_jmp_q    <= irq_jmp_i;
		end
	end

	assign instr_mask_o = pred_error_q || irq_jmp_q;

	// a held cycle allocates no BTB entry.
	a_hold_freeze: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		!hold_n |=> $stable(ent_valid)
	);

endmodule

// File: sim/tb_ctrl_model.svh
// Reference model of the control-flow block, included inside the testbench.
// Keeps a model BTB, the model registered prediction and the model squash
// mask, and gives the expected outputs for the current inputs.

`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

logic                  m_valid [`BTB_ENTRIES];
rv_ctrl_pkg::btb_tag_t m_tag [`BTB_ENTRIES];
rv_ctrl_pkg::addr_t    m_target [`BTB_ENTRIES];
rv_ctrl_pkg::btb_cnt_t m_cnt [`BTB_ENTRIES];
logic                  m_pred_taken;
rv_ctrl_pkg::addr_t    m_pred_target;
logic                  m_err_q;
logic                  m_irq_q;

function automatic logic signed_less(rv_ctrl_pkg::data_t a, rv_ctrl_pkg::data_t b);
	if (a[`RV_DATA_W-1] != b[`RV_DATA_W-1])
		return a[`RV_DATA_W-1]; // the negative operand is the smaller one.
	return a < b;
endfunction

function automatic logic exp_taken(rv_ctrl_pkg::jmp_flag_e flag, rv_ctrl_pkg::data_t a,
		rv_ctrl_pkg::data_t b, logic bypass);
	logic t;
	case (flag)
		rv_ctrl_pkg::JMP_BEQ:  t = (a == b);
		rv_ctrl_pkg::JMP_BNE:  t = (a != b);
		rv_ctrl_pkg::JMP_BLT:  t = signed_less(a, b);
		rv_ctrl_pkg::JMP_BGE:  t = !signed_less(a, b);
		rv_ctrl_pkg::JMP_BLTU: t = (a < b);
		rv_ctrl_pkg::JMP_BGEU: t = (a >= b);
		rv_ctrl_pkg::JMP_J:    t = 1'b1;
		default:               t = 1'b0;
	endcase
	return t && !bypass;
endfunction

function automatic rv_ctrl_pkg::addr_t exp_target(logic taken, rv_ctrl_pkg::addr_t n1,
		rv_ctrl_pkg::addr_t n2);
	return taken ? n1 + n2 : '0;
endfunction

function automatic logic pred_hit(rv_ctrl_pkg::addr_t pc);
	return m_valid[pc[`BTB_IDX_W+1:2]] && (m_tag[pc[`BTB_IDX_W+1:2]] == pc[31:5]);
endfunction

function automatic logic exp_pred_taken(rv_ctrl_pkg::addr_t pc);
	return pred_hit(pc) && (m_cnt[pc[`BTB_IDX_W+1:2]] >= 2);
endfunction

function automatic rv_ctrl_pkg::addr_t exp_pred_target(rv_ctrl_pkg::addr_t pc);
	return pred_hit(pc) ? m_target[pc[`BTB_IDX_W+1:2]] : '0;
endfunction

function automatic logic exp_pred_error(logic taken, rv_ctrl_pkg::addr_t target);
	return (m_pred_taken != taken) || (m_pred_taken && taken && (m_pred_target != target));
endfunction

function automatic rv_ctrl_pkg::hold_code_e exp_hold(logic sif, logic smem);
	return (sif || smem) ? rv_ctrl_pkg::HOLD_EX : rv_ctrl_pkg::HOLD_NONE;
endfunction

`endif

// File: sim/tb_ctrl.sv
// Testbench for the control-flow block.
// Runs directed branch, BTB, interrupt and stall cases, then a random phase,
// and compares every cycle against the model in the included header.

`timescale 1ns/10ps

`include "rv_ctrl_params.svh"

module tb_ctrl;

	localparam int RESET_CYCLES = 5;
	localparam int EVAL_CYCLES = 24;
	localparam int DIRECTED_CYCLES = 18;
	localparam int RAND_CYCLES = 60;
	localparam int TEST_CYCLES = RESET_CYCLES + EVAL_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 2;

	logic clk;
	logic rst_n_i;
	rv_ctrl_pkg::addr_t pc_pred_i, pc_instr_i, jmp_num1_i, jmp_num2_i, irq_jmp_to_i, jmp_to_o;
	rv_ctrl_pkg::data_t data_rs1_i, data_rs2_i;
	rv_ctrl_pkg::jmp_flag_e jmp_flag_i;
	logic load_bypass_i, stall_if_i, stall_mem_i, irq_jmp_i, jmp_en_o, instr_mask_o;
	rv_ctrl_pkg::hold_code_e hold_code_o, e_hold;
	integer seed;
	int cycle_cnt = 0;
	logic e_taken, e_err, e_en;
	rv_ctrl_pkg::addr_t e_target, e_to, addr_a, addr_b, n1, n2;
	rv_ctrl_pkg::data_t rnd;

	`include "tb_ctrl_model.svh"

	ctrl dut (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic rv_ctrl_pkg::addr_t rand_addr();
		return rv_ctrl_pkg::addr_t'($random(seed)) & ~rv_ctrl_pkg::addr_t'(3);
	endfunction

	// a small address window, so that random branches hit trained entries.
	function automatic rv_ctrl_pkg::addr_t pool_addr();
		return 32'h0004_8000 | (rv_ctrl_pkg::addr_t'($random(seed)) & 32'h3c);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		pc_pred_i     <= rand_addr();
		pc_instr_i    <= rand_addr();
		jmp_num1_i    <= $random(seed);
		jmp_num2_i    <= $random(seed);
		data_rs1_i    <= $random(seed);
		data_rs2_i    <= $random(seed);
		jmp_flag_i    <= rv_ctrl_pkg::JMP_NONE;
		load_bypass_i <= 1'b0;
		stall_if_i    <= 1'b0;
		stall_mem_i   <= 1'b0;
		irq_jmp_i     <= 1'b0;
		irq_jmp_to_i  <= rand_addr();
	endtask

	task automatic report_fail(input string what, input rv_ctrl_pkg::addr_t got,
			input rv_ctrl_pkg::addr_t exp);
		$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		$display("Some tests failed");
		$fatal(1, "mismatch on %s", what);
	endtask

	// trains the model BTB and registers by the same edge rules as the pipeline.
	task automatic model_step();
		rv_ctrl_pkg::btb_idx_t i;
		i = pc_instr_i[`BTB_IDX_W+1:2];
		if (e_hold == rv_ctrl_pkg::HOLD_NONE) begin
			m_pred_taken = exp_pred_taken(pc_pred_i);
			m_pred_target = exp_pred_target(pc_pred_i);
			m_err_q = e_err;
			m_irq_q = irq_jmp_i;
			if (jmp_flag_i != rv_ctrl_pkg::JMP_NONE) begin
				if (!pred_hit(pc_instr_i) && e_taken) begin
					m_valid[i] = 1'b1;
					m_tag[i] = pc_instr_i[31:5];
					m_target[i] = e_target;
					m_cnt[i] = `BTB_CNT_INIT;
				end else if (pred_hit(pc_instr_i) && e_taken) begin
					m_target[i] = e_target;
					m_cnt[i] = (m_cnt[i] == 3) ? m_cnt[i] : m_cnt[i] + 1'b1;
				end else if (pred_hit(pc_instr_i)) begin
					m_cnt[i] = (m_cnt[i] == 0) ? m_cnt[i] : m_cnt[i] - 1'b1;
				end
			end
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n_i) begin
			m_valid = '{default: 1'b0};
			m_pred_taken = 1'b0;
			m_pred_target = '0;
			m_err_q = 1'b0;
			m_irq_q = 1'b0;
		end else begin
			e_taken = exp_taken(jmp_flag_i, data_rs1_i, data_rs2_i, load_bypass_i);
			e_target = exp_target(e_taken, jmp_num1_i, jmp_num2_i);
			e_err = exp_pred_error(e_taken, e_target);
			e_hold = exp_hold(stall_if_i, stall_mem_i);
			e_en = irq_jmp_i || e_err || exp_pred_taken(pc_pred_i);
			if (irq_jmp_i)
				e_to = irq_jmp_to_i;
			else if (e_err)
				e_to = e_taken ? e_target : pc_instr_i + 32'd4;
			else
				e_to = exp_pred_target(pc_pred_i);
			assert (jmp_en_o === e_en) else report_fail("jmp_en_o", jmp_en_o, e_en);
			assert (jmp_to_o === e_to) else report_fail("jmp_to_o", jmp_to_o, e_to);
			assert (instr_mask_o === (m_err_q || m_irq_q))
				else report_fail("instr_mask_o", instr_mask_o, m_err_q || m_irq_q);
			assert (hold_code_o === e_hold) else report_fail("hold_code_o", hold_code_o, e_hold);
			model_step();
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= 4 * TEST_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles.", 4 * TEST_CYCLES);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		seed = 32'hfcf1;
		{pc_pred_i, pc_instr_i, jmp_num1_i, jmp_num2_i, irq_jmp_to_i} = '0;
		{data_rs1_i, data_rs2_i} = '0;
		jmp_flag_i = rv_ctrl_pkg::JMP_NONE;
		{rst_n_i, load_bypass_i, stall_if_i, stall_mem_i, irq_jmp_i} = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;
		// every jump class with random, equal and mixed-sign operand pairs.
		for (int f = 0; f < 8; f++) begin
			for (int k = 0; k < 3; k++) begin
				next_cycle();
				rnd = $random(seed);
				jmp_flag_i <= rv_ctrl_pkg::jmp_flag_e'(f);
				if (k == 1) begin
					data_rs1_i <= rnd;
					data_rs2_i <= rnd;
				end else if (k == 2) begin
					data_rs1_i <= (f % 2) ? rnd & 32'h7fff_ffff : rnd | 32'h8000_0000;
					data_rs2_i <= (f % 2) ? rnd | 32'h8000_0000 : rnd & 32'h7fff_ffff;
				end
			end
		end
		addr_a = rand_addr();
		n1 = $random(seed);
		n2 = $random(seed);
		for (int k = 0; k < 3; k++) begin
			next_cycle();
			pc_pred_i <= (k == 1) ? addr_a : rand_addr();
			if (k != 1) begin
				pc_instr_i <= addr_a;
				jmp_flag_i <= rv_ctrl_pkg::JMP_J;
				jmp_num1_i <= n1;
				jmp_num2_i <= n2;
			end
		end
		// equal operands make each BNE at A fall through and untrain it.
		for (int k = 0; k < 6; k++) begin
			next_cycle();
			rnd = $random(seed);
			pc_pred_i <= addr_a;
			if (k < 5) begin
				pc_instr_i <= addr_a;
				jmp_flag_i <= rv_ctrl_pkg::JMP_BNE;
				data_rs1_i <= rnd;
				data_rs2_i <= rnd;
			end
		end
		addr_b = rand_addr();
		for (int k = 0; k < 9; k++) begin
			next_cycle();
			pc_pred_i <= addr_b;
			if (k == 0) begin
				pc_instr_i <= addr_b;
				jmp_flag_i <= rv_ctrl_pkg::JMP_J;
			end
			if (k == 6) begin
				// a fall-through at B that would flip the last prediction if it trained.
				rnd = $random(seed);
				pc_instr_i <= addr_b;
				jmp_flag_i <= rv_ctrl_pkg::JMP_BNE;
				data_rs1_i <= rnd;
				data_rs2_i <= rnd;
			end
			irq_jmp_i <= (k == 0) || (k == 2);
			stall_if_i <= (k == 3) || (k == 6) || (k == 8);
			stall_mem_i <= (k == 4) || (k == 8);
			load_bypass_i <= (k == 7);
			if (k == 7) begin
				pc_instr_i <= addr_b;
				jmp_flag_i <= rv_ctrl_pkg::JMP_J;
			end
		end
		for (int k = 0; k < RAND_CYCLES; k++) begin
			next_cycle();
			pc_pred_i <= pool_addr();
			pc_instr_i <= pool_addr();
			jmp_flag_i <= rv_ctrl_pkg::jmp_flag_e'($random(seed) & 7);
			data_rs1_i <= $random(seed) & 32'h8000_0003;
			data_rs2_i <= $random(seed) & 32'h8000_0003;
			load_bypass_i <= ($random(seed) & 7) == 0;
			stall_if_i <= ($random(seed) & 7) == 0;
			stall_mem_i <= ($random(seed) & 7) == 0;
			irq_jmp_i <= ($random(seed) & 15) == 0;
		end
		next_cycle();
		@(posedge clk);
		$display("All tests passed");
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
+incdir+sim
verilog/rv_ctrl_pkg.sv
verilog/branch_cmp.sv
verilog/btb_update.sv
verilog/btb_entry.sv
verilog/btb_lookup.sv
verilog/ctrl.sv
sim/tb_ctrl.sv

// File: Bender.yml
package:
  name: rv_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_ctrl_pkg.sv
      - verilog/branch_cmp.sv
      - verilog/btb_update.sv
      - verilog/btb_entry.sv
      - verilog/btb_lookup.sv
      - verilog/ctrl.sv
  - target: simulation
    include_dirs:
      - verilog
      - sim
    files:
      - sim/tb_ctrl.sv
